/* include/rd_mon_params.svh */
`ifndef RD_MON_PARAMS_SVH
`define RD_MON_PARAMS_SVH

// port count and field widths
`define RD_MON_NUM_SLV 2
`define RD_MON_ID_W 2
`define RD_MON_NUM_ID (1 << `RD_MON_ID_W)
`define RD_MON_ADDR_W 16
`define RD_MON_DATA_W 16
// beat count is len + 1
`define RD_MON_LEN_W 3

// entries per queue
`define RD_MON_DEPTH 4

// address map, inclusive bounds
`define RD_MON_SLV0_BASE 16'h0000
`define RD_MON_SLV0_END 16'h3FFF
`define RD_MON_SLV1_BASE 16'h8000
`define RD_MON_SLV1_END 16'hBFFF

`endif

/* hdl/rd_mon_pkg.sv */
`include "rd_mon_params.svh"

package rd_mon_pkg;

  typedef logic [`RD_MON_ID_W-1:0] id_t;
  typedef logic [`RD_MON_LEN_W-1:0] len_t;
  typedef logic [$clog2(`RD_MON_NUM_SLV)-1:0] slv_idx_t;

  // read request, as seen on AR
  typedef struct packed {
    id_t                      id;
    logic [`RD_MON_ADDR_W-1:0] addr;
    len_t                     len;
  } ar_req_t;

  typedef struct packed {
    logic    fire;
    ar_req_t req;
  } ar_mon_t;

  // one read data beat
  typedef struct packed {
    id_t                      id;
    logic [`RD_MON_DATA_W-1:0] data;
    logic [1:0]               resp;
    logic                     last;
  } r_beat_t;

  typedef struct packed {
    logic    fire;
    r_beat_t beat;
  } r_mon_t;

  // owning slave and beats still due after the current one
  typedef struct packed {
    slv_idx_t slv;
    len_t     cnt;
  } route_t;

  typedef struct packed {
    logic dec_miss;
    logic ar_mismatch;
    logic ar_unexpected;
    logic r_unexpected;
    logic r_mismatch;
  } mon_err_t;

endpackage

/* hdl/expect_fifo.sv */
`timescale 1ns/1ps

module expect_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 4
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t head_o,
  output logic     empty_o,
  output logic     full_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             do_push;
  logic             do_pop;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == (PTR_W+1)'(DEPTH));

  // show-ahead, the oldest entry is always visible
  assign head_o = mem_q[rd_ptr_q];

  assign do_pop  = pop_i && !empty_o;
  // a same-cycle pop frees the slot for a push into a full queue
  assign do_push = push_i && (!full_o || do_pop);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

/* hdl/rd_addr_decode.sv */
`timescale 1ns/1ps
`include "rd_mon_params.svh"

module rd_addr_decode (
  input  logic [`RD_MON_ADDR_W-1:0] addr_i,
  output rd_mon_pkg::slv_idx_t      slv_idx_o,
  output logic                      hit_o
);

  // region i belongs to slave i
  localparam logic [`RD_MON_NUM_SLV-1:0][`RD_MON_ADDR_W-1:0] BASE =
    {`RD_MON_SLV1_BASE, `RD_MON_SLV0_BASE};
  localparam logic [`RD_MON_NUM_SLV-1:0][`RD_MON_ADDR_W-1:0] LIMIT =
    {`RD_MON_SLV1_END, `RD_MON_SLV0_END};

  always_comb begin
    slv_idx_o = '0;
    hit_o     = 1'b0;
    for (int i = 0; i < `RD_MON_NUM_SLV; i++) begin
      if (addr_i >= BASE[i] && addr_i <= LIMIT[i]) begin
        slv_idx_o = rd_mon_pkg::slv_idx_t'(i);
        hit_o     = 1'b1;
      end
    end
  end

endmodule

/* hdl/slv_port_tracker.sv */
`timescale 1ns/1ps
`include "rd_mon_params.svh"

module slv_port_tracker (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  logic                                      exp_push_i,
  input  rd_mon_pkg::ar_req_t                       exp_req_i,
  input  rd_mon_pkg::ar_mon_t                       slv_ar_i,
  input  rd_mon_pkg::r_mon_t                        slv_r_i,
  input  logic [`RD_MON_NUM_ID-1:0]                 beat_pop_i,
  output rd_mon_pkg::r_beat_t [`RD_MON_NUM_ID-1:0]  beat_head_o,
  output logic [`RD_MON_NUM_ID-1:0]                 beat_empty_o,
  output logic                                      ar_mismatch_o,
  output logic                                      ar_unexpected_o,
  output logic                                      r_unexpected_o,
  output logic                                      idle_o
);

  rd_mon_pkg::ar_req_t exp_head;
  logic                exp_empty;
  rd_mon_pkg::id_t     id_head;
  logic                id_empty;
  logic                req_match;
  logic                id_push;
  logic                id_pop;
  rd_mon_pkg::r_beat_t stamped;

  // requests expected at this port, in master order
  expect_fifo #(
    .payload_t (rd_mon_pkg::ar_req_t),
    .DEPTH     (`RD_MON_DEPTH)
  ) u_exp_q (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (exp_push_i),
    .data_i   (exp_req_i),
    .pop_i    (slv_ar_i.fire),
    .head_o   (exp_head),
    .empty_o  (exp_empty),
    .full_o   ()
  );

  // slave side id is not compared, the interconnect may remap it
  assign req_match = (slv_ar_i.req.addr == exp_head.addr) &&
                     (slv_ar_i.req.len == exp_head.len);

  assign ar_unexpected_o = slv_ar_i.fire && exp_empty;
  assign ar_mismatch_o   = slv_ar_i.fire && !exp_empty && !req_match;
  assign id_push         = slv_ar_i.fire && !exp_empty && req_match;

  // original ids of bursts in flight at this slave
  expect_fifo #(
    .payload_t (rd_mon_pkg::id_t),
    .DEPTH     (`RD_MON_DEPTH)
  ) u_id_q (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (id_push),
    .data_i   (exp_head.id),
    .pop_i    (id_pop),
    .head_o   (id_head),
    .empty_o  (id_empty),
    .full_o   ()
  );

  // slave answers in order, so the burst ends on last
  assign id_pop         = slv_r_i.fire && slv_r_i.beat.last;
  assign r_unexpected_o = slv_r_i.fire && id_empty;

  always_comb begin
    stamped    = slv_r_i.beat;
    stamped.id = id_head;
  end

  for (genvar i = 0; i < `RD_MON_NUM_ID; i++) begin : gen_beat_q
    logic push;

    assign push = slv_r_i.fire && !id_empty && (id_head == rd_mon_pkg::id_t'(i));

    expect_fifo #(
      .payload_t (rd_mon_pkg::r_beat_t),
      .DEPTH     (`RD_MON_DEPTH)
    ) u_beat_q (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .push_i   (push),
      .data_i   (stamped),
      .pop_i    (beat_pop_i[i]),
      .head_o   (beat_head_o[i]),
      .empty_o  (beat_empty_o[i]),
      .full_o   ()
    );
  end

  assign idle_o = exp_empty && id_empty && (&beat_empty_o);

endmodule

/* hdl/mst_rsp_checker.sv */
`timescale 1ns/1ps
`include "rd_mon_params.svh"

module mst_rsp_checker (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                route_push_i,
  input  rd_mon_pkg::route_t  route_i,
  input  rd_mon_pkg::id_t     route_id_i,
  input  rd_mon_pkg::r_mon_t  mst_r_i,
  input  rd_mon_pkg::r_beat_t [`RD_MON_NUM_SLV-1:0][`RD_MON_NUM_ID-1:0] beat_head_i,
  input  logic [`RD_MON_NUM_SLV-1:0][`RD_MON_NUM_ID-1:0]                beat_empty_i,
  output logic [`RD_MON_NUM_SLV-1:0][`RD_MON_NUM_ID-1:0]                beat_pop_o,
  output logic                r_mismatch_o,
  output logic                idle_o
);

  rd_mon_pkg::route_t [`RD_MON_NUM_ID-1:0] route_head;
  logic [`RD_MON_NUM_ID-1:0]               route_empty;
  logic [`RD_MON_NUM_ID-1:0]               route_pop;
  rd_mon_pkg::len_t [`RD_MON_NUM_ID-1:0]   beat_cnt_q;
  rd_mon_pkg::id_t                         r_id;
  rd_mon_pkg::route_t                      cur_route;
  rd_mon_pkg::len_t                        remaining;

  // one route queue per id, oldest outstanding read at the head
  for (genvar i = 0; i < `RD_MON_NUM_ID; i++) begin : gen_route_q
    logic push;

    assign push = route_push_i && (route_id_i == rd_mon_pkg::id_t'(i));

    expect_fifo #(
      .payload_t (rd_mon_pkg::route_t),
      .DEPTH     (`RD_MON_DEPTH)
    ) u_route_q (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .push_i   (push),
      .data_i   (route_i),
      .pop_i    (route_pop[i]),
      .head_o   (route_head[i]),
      .empty_o  (route_empty[i]),
      .full_o   ()
    );
  end

  assign r_id      = mst_r_i.beat.id;
  assign cur_route = route_head[r_id];
  // beats still due after this one
  assign remaining = cur_route.cnt - beat_cnt_q[r_id];

  always_comb begin
    beat_pop_o   = '0;
    route_pop    = '0;
    r_mismatch_o = 1'b0;
    if (mst_r_i.fire) begin
      if (route_empty[r_id]) begin
        r_mismatch_o = 1'b1;
      end else begin
        route_pop[r_id] = (remaining == '0);
        if (beat_empty_i[cur_route.slv][r_id]) begin
          // beat reached the master before the slave sent it
          r_mismatch_o = 1'b1;
        end else begin
          beat_pop_o[cur_route.slv][r_id] = 1'b1;
          r_mismatch_o = (beat_head_i[cur_route.slv][r_id] != mst_r_i.beat);
        end
      end
    end
  end

  // beats already seen of the head burst, per id
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      beat_cnt_q <= '0;
    end else if (mst_r_i.fire && !route_empty[r_id]) begin
      if (remaining == '0) begin
        beat_cnt_q[r_id] <= '0;
      end else begin
        beat_cnt_q[r_id] <= beat_cnt_q[r_id] + 1'b1;
      end
    end
  end

  assign idle_o = &route_empty;

endmodule

/* hdl/read_order_monitor.sv */
`timescale 1ns/1ps
`include "rd_mon_params.svh"

module read_order_monitor (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  input  rd_mon_pkg::ar_mon_t                      mst_ar_i,
  input  rd_mon_pkg::r_mon_t                       mst_r_i,
  input  rd_mon_pkg::ar_mon_t [`RD_MON_NUM_SLV-1:0] slv_ar_i,
  input  rd_mon_pkg::r_mon_t [`RD_MON_NUM_SLV-1:0]  slv_r_i,
  output rd_mon_pkg::mon_err_t                     err_o,
  output logic                                     idle_o
);

  rd_mon_pkg::slv_idx_t dec_idx;
  logic                 dec_hit;
  logic                 route_push;
  rd_mon_pkg::route_t   route;

  logic [`RD_MON_NUM_SLV-1:0] exp_push;
  logic [`RD_MON_NUM_SLV-1:0] trk_ar_mismatch;
  logic [`RD_MON_NUM_SLV-1:0] trk_ar_unexpected;
  logic [`RD_MON_NUM_SLV-1:0] trk_r_unexpected;
  logic [`RD_MON_NUM_SLV-1:0] trk_idle;
  logic                       chk_r_mismatch;
  logic                       chk_idle;

  rd_mon_pkg::r_beat_t [`RD_MON_NUM_SLV-1:0][`RD_MON_NUM_ID-1:0] beat_head;
  logic [`RD_MON_NUM_SLV-1:0][`RD_MON_NUM_ID-1:0]                beat_empty;
  logic [`RD_MON_NUM_SLV-1:0][`RD_MON_NUM_ID-1:0]                beat_pop;

  rd_mon_pkg::mon_err_t err_d;
  rd_mon_pkg::mon_err_t err_q;

  rd_addr_decode u_dec (
    .addr_i    (mst_ar_i.req.addr),
    .slv_idx_o (dec_idx),
    .hit_o     (dec_hit)
  );

  // a decoded request is expected at one slave and routes its beats back
  assign route_push = mst_ar_i.fire && dec_hit;

  always_comb begin
    route.slv = dec_idx;
    route.cnt = mst_ar_i.req.len;
  end

  for (genvar s = 0; s < `RD_MON_NUM_SLV; s++) begin : gen_trk
    assign exp_push[s] = route_push && (dec_idx == rd_mon_pkg::slv_idx_t'(s));

    slv_port_tracker u_trk (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .exp_push_i      (exp_push[s]),
      .exp_req_i       (mst_ar_i.req),
      .slv_ar_i        (slv_ar_i[s]),
      .slv_r_i         (slv_r_i[s]),
      .beat_pop_i      (beat_pop[s]),
      .beat_head_o     (beat_head[s]),
      .beat_empty_o    (beat_empty[s]),
      .ar_mismatch_o   (trk_ar_mismatch[s]),
      .ar_unexpected_o (trk_ar_unexpected[s]),
      .r_unexpected_o  (trk_r_unexpected[s]),
      .idle_o          (trk_idle[s])
    );
  end

  mst_rsp_checker u_chk (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .route_push_i (route_push),
    .route_i      (route),
    .route_id_i   (mst_ar_i.req.id),
    .mst_r_i      (mst_r_i),
    .beat_head_i  (beat_head),
    .beat_empty_i (beat_empty),
    .beat_pop_o   (beat_pop),
    .r_mismatch_o (chk_r_mismatch),
    .idle_o       (chk_idle)
  );

  // flags only ever set, cleared by reset alone
  always_comb begin
    err_d.dec_miss      = err_q.dec_miss | (mst_ar_i.fire & ~dec_hit);
    err_d.ar_mismatch   = err_q.ar_mismatch | (|trk_ar_mismatch);
    err_d.ar_unexpected = err_q.ar_unexpected | (|trk_ar_unexpected);
    err_d.r_unexpected  = err_q.r_unexpected | (|trk_r_unexpected);
    err_d.r_mismatch    = err_q.r_mismatch | chk_r_mismatch;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_q <= '0;
    end else begin
      err_q <= err_d;
    end
  end

  assign err_o  = err_q;
  assign idle_o = (&trk_idle) && chk_idle;

endmodule

/* bench/rd_mon_checker.sv */
`timescale 1ns/1ps
`include "rd_mon_params.svh"

module rd_mon_checker (
  input logic                                    clk_i,
  input logic                                    arst_n_i,
  input logic [$bits(rd_mon_pkg::mon_err_t)-1:0] err_i,
  input logic                                    idle_i
);

  int unsigned assert_fail_cnt = 0;

  logic [`RD_MON_NUM_SLV-1:0][`RD_MON_NUM_ID+1:0] trk_ovf;
  logic [`RD_MON_NUM_ID-1:0]                      route_ovf;

  // a pop in the same cycle frees the slot, so that push is legal
  function automatic logic overflow(input logic push, input logic full, input logic pop);
    return push && full && !pop;
  endfunction

  for (genvar s = 0; s < `RD_MON_NUM_SLV; s++) begin : g_trk_ovf
    assign trk_ovf[s][0] = overflow(gen_trk[s].u_trk.u_exp_q.push_i,
                                    gen_trk[s].u_trk.u_exp_q.full_o,
                                    gen_trk[s].u_trk.u_exp_q.pop_i);
    assign trk_ovf[s][1] = overflow(gen_trk[s].u_trk.u_id_q.push_i,
                                    gen_trk[s].u_trk.u_id_q.full_o,
                                    gen_trk[s].u_trk.u_id_q.pop_i);
    for (genvar i = 0; i < `RD_MON_NUM_ID; i++) begin : g_beat_ovf
      assign trk_ovf[s][i+2] = overflow(gen_trk[s].u_trk.gen_beat_q[i].u_beat_q.push_i,
                                        gen_trk[s].u_trk.gen_beat_q[i].u_beat_q.full_o,
                                        gen_trk[s].u_trk.gen_beat_q[i].u_beat_q.pop_i);
    end
  end

  for (genvar i = 0; i < `RD_MON_NUM_ID; i++) begin : g_route_ovf
    assign route_ovf[i] = overflow(u_chk.gen_route_q[i].u_route_q.push_i,
                                   u_chk.gen_route_q[i].u_route_q.full_o,
                                   u_chk.gen_route_q[i].u_route_q.pop_i);
  end

  a_no_push_when_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (trk_ovf == '0) && (route_ovf == '0))
  else begin
    $error("a monitor queue was pushed while full");
    assert_fail_cnt++;
  end

  // sticky flags, only reset clears them
  a_flags_sticky: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ($past(err_i) & ~err_i) == '0)
  else begin
    $error("an error flag fell without reset");
    assert_fail_cnt++;
  end

  a_idle_after_reset: assert property (@(posedge clk_i) $rose(arst_n_i) |-> idle_i)
  else begin
    $error("monitor not idle after reset");
    assert_fail_cnt++;
  end

endmodule

bind read_order_monitor rd_mon_checker u_mon_chk (
  .clk_i    (clk_i),
  .arst_n_i (arst_n_i),
  .err_i    (err_o),
  .idle_i   (idle_o)
);

/* bench/tb_read_order_monitor.sv */
`timescale 1ns/1ps
`include "rd_mon_params.svh"

module tb_read_order_monitor;

  localparam int NUM_TESTS       = 6;
  localparam int MAX_TEST_CYCLES = 500;
  localparam int ROUNDS          = 6;
  localparam int MAX_TXN         = `RD_MON_DEPTH;
  localparam int MAX_BEATS       = 1 << `RD_MON_LEN_W;
  // longest test bound per test, plus slack for the resets
  localparam int WATCHDOG_NS     = NUM_TESTS * MAX_TEST_CYCLES * 20 + 2000;

  logic                                      clk_i;
  logic                                      arst_n_i;
  rd_mon_pkg::ar_mon_t                       mst_ar;
  rd_mon_pkg::r_mon_t                        mst_r;
  rd_mon_pkg::ar_mon_t [`RD_MON_NUM_SLV-1:0] slv_ar;
  rd_mon_pkg::r_mon_t [`RD_MON_NUM_SLV-1:0]  slv_r;
  rd_mon_pkg::mon_err_t                      err;
  logic                                      idle;

  // transactions of the current test, as the interconnect model sees them
  rd_mon_pkg::id_t           t_id [MAX_TXN];
  logic [`RD_MON_ADDR_W-1:0] t_addr [MAX_TXN];
  rd_mon_pkg::len_t          t_len [MAX_TXN];
  int                        t_slv [MAX_TXN];
  logic [`RD_MON_DATA_W-1:0] t_data [MAX_TXN][MAX_BEATS];

  logic [31:0] seed;
  int          check_errs;
  int          total_errs;
  int          test_num;
  int          fail_tests;

  read_order_monitor dut0 (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .mst_ar_i (mst_ar),
    .mst_r_i  (mst_r),
    .slv_ar_i (slv_ar),
    .slv_r_i  (slv_r),
    .err_o    (err),
    .idle_o   (idle)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all tests finished");
    $display("Regression failed");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = lcg_next();
    return int'(r[31:16]) % n;
  endfunction

  // address map of the interconnect, -1 for a miss
  function automatic int decode_addr(input logic [`RD_MON_ADDR_W-1:0] a);
    if (a >= `RD_MON_SLV0_BASE && a <= `RD_MON_SLV0_END) begin
      return 0;
    end
    if (a >= `RD_MON_SLV1_BASE && a <= `RD_MON_SLV1_END) begin
      return 1;
    end
    return -1;
  endfunction

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      check_errs++;
    end
  endtask

  task automatic next_cycle();
    @(negedge clk_i);
    mst_ar.fire = 1'b0;
    mst_r.fire  = 1'b0;
    for (int s = 0; s < `RD_MON_NUM_SLV; s++) begin
      slv_ar[s].fire = 1'b0;
      slv_r[s].fire  = 1'b0;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic apply_reset();
    mst_ar   = '0;
    mst_r    = '0;
    slv_ar   = '0;
    slv_r    = '0;
    arst_n_i = 1'b0;
    repeat (4) @(negedge clk_i);
    arst_n_i = 1'b1;
  endtask

  // slv < 0 lets the address land in any region
  task automatic new_txn(input int k, input int id, input int slv, input int len);
    logic [31:0] r;
    t_id[k]  = rd_mon_pkg::id_t'(id);
    t_len[k] = rd_mon_pkg::len_t'(len);
    do begin
      r         = lcg_next();
      t_addr[k] = r[31:16];
      t_slv[k]  = decode_addr(t_addr[k]);
    end while (t_slv[k] < 0 || (slv >= 0 && t_slv[k] != slv));
    for (int b = 0; b < MAX_BEATS; b++) begin
      r            = lcg_next();
      t_data[k][b] = r[31:16];
    end
  endtask

  task automatic send_mst_ar(input int k);
    mst_ar.fire     = 1'b1;
    mst_ar.req.id   = t_id[k];
    mst_ar.req.addr = t_addr[k];
    mst_ar.req.len  = t_len[k];
    next_cycle();
  endtask

  // slave side id is remapped at random
  task automatic send_slv_ar(input int k, input int s);
    slv_ar[s].fire     = 1'b1;
    slv_ar[s].req.id   = rd_mon_pkg::id_t'(rand_below(`RD_MON_NUM_ID));
    slv_ar[s].req.addr = t_addr[k];
    slv_ar[s].req.len  = t_len[k];
    next_cycle();
  endtask

  task automatic drive_slv_beat(input int s, input logic [`RD_MON_DATA_W-1:0] d,
                                input logic last);
    slv_r[s].fire      = 1'b1;
    slv_r[s].beat.id   = rd_mon_pkg::id_t'(rand_below(`RD_MON_NUM_ID));
    slv_r[s].beat.data = d;
    slv_r[s].beat.resp = 2'b00;
    slv_r[s].beat.last = last;
  endtask

  task automatic drive_mst_beat(input rd_mon_pkg::id_t id, input logic [`RD_MON_DATA_W-1:0] d,
                                input logic last);
    mst_r.fire      = 1'b1;
    mst_r.beat.id   = id;
    mst_r.beat.data = d;
    mst_r.beat.resp = 2'b00;
    mst_r.beat.last = last;
  endtask

  // slave beat b goes out while the master takes beat b-1
  task automatic return_burst(input int k, input int bad_beat);
    int                        n;
    logic [`RD_MON_DATA_W-1:0] d;
    n = int'(t_len[k]) + 1;
    for (int b = 0; b <= n; b++) begin
      if (b < n) begin
        drive_slv_beat(t_slv[k], t_data[k][b], b == n - 1);
      end
      if (b > 0) begin
        d = t_data[k][b-1];
        if (b - 1 == bad_beat) begin
          d = ~d;
        end
        drive_mst_beat(t_id[k], d, b == n);
      end
      next_cycle();
    end
  endtask

  task automatic check_flags(input rd_mon_pkg::mon_err_t exp_err, input logic exp_idle);
    compare("err_o", 32'(err), 32'(exp_err));
    compare("idle_o", 32'(idle), 32'(exp_idle));
  endtask

  task automatic report_test(input string name);
    test_num++;
    if (check_errs == 0) begin
      $display("test %0d %s: ok", test_num, name);
    end else begin
      $display("test %0d %s: %0d check(s) wrong", test_num, name, check_errs);
      fail_tests++;
    end
    total_errs += check_errs;
    check_errs = 0;
  endtask

  task automatic random_traffic();
    int n;
    apply_reset();
    for (int r = 0; r < ROUNDS; r++) begin
      n = 1 + rand_below(MAX_TXN);
      for (int k = 0; k < n; k++) begin
        new_txn(k, rand_below(`RD_MON_NUM_ID), -1, rand_below(MAX_BEATS));
        send_mst_ar(k);
        idle_cycles(rand_below(3));
      end
      // in master order, which keeps both slave order and per-id order
      for (int k = 0; k < n; k++) begin
        send_slv_ar(k, t_slv[k]);
        idle_cycles(rand_below(3));
      end
      for (int k = 0; k < n; k++) begin
        return_burst(k, -1);
        idle_cycles(rand_below(3));
      end
    end
    check_flags('0, 1'b1);
    report_test("random legal traffic");
  endtask

  task automatic interleaved_ids();
    int id0;
    apply_reset();
    id0 = rand_below(`RD_MON_NUM_ID);
    new_txn(0, id0, 0, 3);
    new_txn(1, id0 ^ 1, 1, 3);
    send_mst_ar(0);
    send_mst_ar(1);
    send_slv_ar(0, 0);
    send_slv_ar(1, 1);
    for (int b = 0; b < 4; b++) begin
      drive_slv_beat(0, t_data[0][b], b == 3);
      drive_slv_beat(1, t_data[1][b], b == 3);
      next_cycle();
    end
    for (int b = 0; b < 4; b++) begin
      drive_mst_beat(t_id[0], t_data[0][b], b == 3);
      next_cycle();
      drive_mst_beat(t_id[1], t_data[1][b], b == 3);
      next_cycle();
    end
    check_flags('0, 1'b1);
    report_test("interleaved ids");
  endtask

  task automatic misrouted_request();
    rd_mon_pkg::mon_err_t exp_err;
    apply_reset();
    new_txn(0, rand_below(`RD_MON_NUM_ID), 0, rand_below(4));
    send_mst_ar(0);
    send_slv_ar(0, 1);
    exp_err               = '0;
    exp_err.ar_unexpected = 1'b1;
    // the slave 0 expectation is still pending
    check_flags(exp_err, 1'b0);
    report_test("request at wrong slave");
  endtask

  task automatic corrupted_beat();
    rd_mon_pkg::mon_err_t exp_err;
    apply_reset();
    new_txn(0, rand_below(`RD_MON_NUM_ID), -1, rand_below(4));
    send_mst_ar(0);
    send_slv_ar(0, t_slv[0]);
    return_burst(0, rand_below(int'(t_len[0]) + 1));
    exp_err            = '0;
    exp_err.r_mismatch = 1'b1;
    check_flags(exp_err, 1'b1);
    report_test("corrupted beat");
  endtask

  task automatic swapped_bursts();
    rd_mon_pkg::mon_err_t exp_err;
    int                   id;
    apply_reset();
    id = rand_below(`RD_MON_NUM_ID);
    new_txn(0, id, 0, 1);
    new_txn(1, id, 1, 1);
    send_mst_ar(0);
    send_mst_ar(1);
    send_slv_ar(0, 0);
    send_slv_ar(1, 1);
    // younger read reaches the master first
    return_burst(1, -1);
    return_burst(0, -1);
    exp_err            = '0;
    exp_err.r_mismatch = 1'b1;
    compare("err_o", 32'(err), 32'(exp_err));
    report_test("same id swapped");
  endtask

  task automatic decode_miss();
    rd_mon_pkg::mon_err_t exp_err;
    apply_reset();
    new_txn(0, rand_below(`RD_MON_NUM_ID), -1, 0);
    t_addr[0] = 16'h5000;
    send_mst_ar(0);
    exp_err          = '0;
    exp_err.dec_miss = (decode_addr(t_addr[0]) < 0);
    check_flags(exp_err, 1'b1);
    new_txn(1, rand_below(`RD_MON_NUM_ID), -1, rand_below(4));
    send_mst_ar(1);
    compare("idle_o while outstanding", 32'(idle), 32'd0);
    send_slv_ar(1, t_slv[1]);
    return_burst(1, -1);
    check_flags(exp_err, 1'b1);
    report_test("decode miss and idle");
  endtask

  initial begin
    seed       = 32'habaf;
    check_errs = 0;
    total_errs = 0;
    test_num   = 0;
    fail_tests = 0;
    random_traffic();
    interleaved_ids();
    misrouted_request();
    corrupted_beat();
    swapped_bursts();
    decode_miss();
    $display("tests %0d, failed tests %0d, failed checks %0d, assertion failures %0d",
             test_num, fail_tests, total_errs, dut0.u_mon_chk.assert_fail_cnt);
    if (fail_tests == 0 && dut0.u_mon_chk.assert_fail_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+include
hdl/rd_mon_pkg.sv
hdl/expect_fifo.sv
hdl/rd_addr_decode.sv
hdl/slv_port_tracker.sv
hdl/mst_rsp_checker.sv
hdl/read_order_monitor.sv
bench/rd_mon_checker.sv
bench/tb_read_order_monitor.sv

/* run_sim.sh */
#!/bin/sh
# build and run the read-order monitor testbench with Verilator
LOG=sim.log

verilator --binary --assert -Wno-fatal -f verilog.f \
  --top-module tb_read_order_monitor -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
